//--- design/whac_pkg.sv
package whac_pkg;

	// Hole number on the 4x4 board, 0 to 15
	typedef logic [3:0] hole_t;

	// Mole position; bit 4 set means no mole on the board
	typedef logic [4:0] mole_t;

	// One BCD digit
	typedef logic [3:0] bcd_t;

	// Cycle counter, wide enough for one second at 1 MHz
	typedef logic [19:0] tick_t;

	// Segments a to g, a in bit 6 and g in bit 0, active high
	typedef logic [6:0] seg_t;

	// Three phases of one mole cycle
	typedef enum logic [1:0] {
		MOLE_SHOW,
		MOLE_LINGER,
		MOLE_HIDDEN
	} mole_state_t;

	// The only legal hidden value
	localparam mole_t MOLE_NONE = 5'b1_0000;

	// Cycles per mole phase, minus one
	localparam int DEF_STEP_TICKS = 500000;

	// 1 MHz clock
	localparam int DEF_TICKS_PER_SEC = 1000000;

	// Game length in seconds, two BCD digits
	localparam int DEF_GAME_SECONDS = 30;

endpackage

//--- design/press_sync.sv
`timescale 1ns/100ps

module press_sync (
	input  logic clk_1us,
	input  logic reset,
	input  logic button,
	output logic press_valid
);

	logic sync_meta;
	logic sync_level;
	logic level_prev;

	// Two flops bring the raw button into the clock domain
	always_ff @(posedge clk_1us or negedge reset) begin
		if (!reset) begin
			sync_meta  <= 1'b0;
			sync_level <= 1'b0;
		end else begin
			sync_meta  <= button;
			sync_level <= sync_meta;
		end
	end

	// Rising edge of the synchronized level, registered
	always_ff @(posedge clk_1us or negedge reset) begin
		if (!reset) begin
			level_prev  <= 1'b0;
			press_valid <= 1'b0;
		end else begin
			level_prev  <= sync_level;
			press_valid <= sync_level & ~level_prev;
		end
	end

	// A held button must give a single strobe
	a_single_pulse: assert property (
		@(posedge clk_1us) disable iff (!reset)
		press_valid |=> !press_valid
	) else $error("press_valid high on two cycles in a row");

endmodule

//--- design/mole_lfsr.sv
`timescale 1ns/100ps

module mole_lfsr (
	input  logic           clk_1us,
	input  logic           reset,
	output whac_pkg::hole_t random
);

	// Any nonzero start value works
	localparam logic [15:0] SEED = 16'hace1;

	logic [15:0] lfsr;
	logic        feedback;

	// Taps 16, 15, 13, 4 give the full 65535-state sequence
	assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

	always_ff @(posedge clk_1us or negedge reset) begin
		if (!reset) begin
			lfsr <= SEED;
		end else begin
			lfsr <= {lfsr[14:0], feedback};
		end
	end

	// Spread-out bits, so neighbouring holes are not favoured
	assign random = {lfsr[13], lfsr[9], lfsr[5], lfsr[1]};

endmodule

//--- design/game_timer.sv
`timescale 1ns/100ps

module game_timer #(
	parameter int TICKS_PER_SEC = whac_pkg::DEF_TICKS_PER_SEC,
	parameter int GAME_SECONDS  = whac_pkg::DEF_GAME_SECONDS
) (
	input  logic          clk_1us,
	input  logic          reset,
	output whac_pkg::bcd_t time_tens,
	output whac_pkg::bcd_t time_ones,
	output logic          timesup
);

	import whac_pkg::*;

	localparam bcd_t  START_TENS = bcd_t'(GAME_SECONDS / 10);
	localparam bcd_t  START_ONES = bcd_t'(GAME_SECONDS % 10);
	localparam tick_t LAST_TICK  = tick_t'(TICKS_PER_SEC - 1);

	tick_t tick_count;
	logic  sec_tick;
	logic  at_zero;

	assign sec_tick = (tick_count == LAST_TICK);
	assign at_zero  = (time_tens == 4'd0) && (time_ones == 4'd0);

	// One-second divider
	always_ff @(posedge clk_1us or negedge reset) begin
		if (!reset) begin
			tick_count <= '0;
		end else if (sec_tick) begin
			tick_count <= '0;
		end else begin
			tick_count <= tick_count + 1'b1;
		end
	end

	// BCD countdown, holds at 00
	always_ff @(posedge clk_1us or negedge reset) begin
		if (!reset) begin
			time_tens <= START_TENS;
			time_ones <= START_ONES;
		end else if (sec_tick && !at_zero) begin
			if (time_ones == 4'd0) begin
				time_ones <= 4'd9;
				time_tens <= time_tens - 1'b1;
			end else begin
				time_ones <= time_ones - 1'b1;
			end
		end
	end

	// Sticky until reset
	always_ff @(posedge clk_1us or negedge reset) begin
		if (!reset) begin
			timesup <= 1'b0;
		end else if (at_zero) begin
			timesup <= 1'b1;
		end
	end

	a_timesup_sticky: assert property (
		@(posedge clk_1us) disable iff (!reset)
		timesup |=> timesup
	) else $error("timesup fell during a game");

	a_digits_bcd: assert property (
		@(posedge clk_1us) disable iff (!reset)
		(time_tens <= 4'd9) && (time_ones <= 4'd9)
	) else $error("time digit out of BCD range");

endmodule

//--- design/mole_ctrl.sv
`timescale 1ns/100ps

module mole_ctrl #(
	parameter int STEP_TICKS = whac_pkg::DEF_STEP_TICKS
) (
	input  logic            clk_1us,
	input  logic            reset,
	input  logic            press_valid,
	input  whac_pkg::hole_t mallet_position,
	input  whac_pkg::hole_t random,
	input  logic            timesup,
	output whac_pkg::mole_t mole_position,
	output whac_pkg::bcd_t  score_tens,
	output whac_pkg::bcd_t  score_ones
);

	import whac_pkg::*;

	localparam tick_t LAST_STEP = tick_t'(STEP_TICKS);

	mole_state_t state;
	mole_state_t next_state;
	tick_t       phase_count;
	tick_t       next_phase_count;
	logic        new_mole;
	logic        next_new_mole;
	mole_t       next_mole;
	bcd_t        next_score_tens;
	bcd_t        next_score_ones;
	logic        phase_done;
	logic        hit;

	assign phase_done = (phase_count == LAST_STEP);

	// Only a visible mole can be hit
	assign hit = press_valid && !timesup && !mole_position[4] &&
		(mallet_position == mole_position[3:0]);

	always_ff @(posedge clk_1us or negedge reset) begin
		if (!reset) begin
			state         <= MOLE_HIDDEN;
			phase_count   <= '0;
			new_mole      <= 1'b0;
			mole_position <= MOLE_NONE;
			score_tens    <= 4'd0;
			score_ones    <= 4'd0;
		end else begin
			state         <= next_state;
			phase_count   <= next_phase_count;
			new_mole      <= next_new_mole;
			mole_position <= next_mole;
			score_tens    <= next_score_tens;
			score_ones    <= next_score_ones;
		end
	end

	// Phase sequencing
	always_comb begin
		next_state       = state;
		next_phase_count = phase_count + 1'b1;
		next_new_mole    = 1'b0;
		case (state)
			MOLE_SHOW: begin
				if (hit) begin
					next_state       = MOLE_HIDDEN;
					next_phase_count = '0;
				end else if (phase_done) begin
					next_state       = MOLE_LINGER;
					next_phase_count = '0;
				end
			end
			MOLE_LINGER: begin
				if (hit || phase_done) begin
					next_state       = MOLE_HIDDEN;
					next_phase_count = '0;
				end
			end
			MOLE_HIDDEN: begin
				if (phase_done) begin
					next_state       = MOLE_SHOW;
					next_phase_count = '0;
					next_new_mole    = 1'b1;
				end
			end
			default: begin
				next_state       = MOLE_HIDDEN;
				next_phase_count = '0;
			end
		endcase
	end

	// Mole position; no new mole once time is up
	always_comb begin
		if (hit || (state == MOLE_HIDDEN)) begin
			next_mole = MOLE_NONE;
		end else if (new_mole && !timesup) begin
			next_mole = {1'b0, random};
		end else begin
			next_mole = mole_position;
		end
	end

	// Two-digit BCD score, wraps 99 to 00
	always_comb begin
		next_score_tens = score_tens;
		next_score_ones = score_ones;
		if (hit) begin
			if (score_ones == 4'd9) begin
				next_score_ones = 4'd0;
				next_score_tens = (score_tens == 4'd9) ? 4'd0 : score_tens + 1'b1;
			end else begin
				next_score_ones = score_ones + 1'b1;
			end
		end
	end

	a_hidden_exact: assert property (
		@(posedge clk_1us) disable iff (!reset)
		mole_position[4] |-> (mole_position == MOLE_NONE)
	) else $error("hidden mole position is not 16");

	// Score moves only on the cycle after a qualifying press
	a_score_needs_hit: assert property (
		@(posedge clk_1us) disable iff (!reset)
		!$stable({score_tens, score_ones}) |-> $past(hit)
	) else $error("score changed without a hit");

endmodule

//--- design/board_display.sv
`timescale 1ns/100ps

module board_display (
	input  whac_pkg::bcd_t  score_tens,
	input  whac_pkg::bcd_t  score_ones,
	input  whac_pkg::bcd_t  time_tens,
	input  whac_pkg::bcd_t  time_ones,
	input  whac_pkg::mole_t mole_position,
	output whac_pkg::seg_t  seg_score_tens,
	output whac_pkg::seg_t  seg_score_ones,
	output whac_pkg::seg_t  seg_time_tens,
	output whac_pkg::seg_t  seg_time_ones,
	output logic [15:0]     hole_leds
);

	import whac_pkg::*;

	// Pattern order is a b c d e f g
	function automatic seg_t bcd_to_seg(input bcd_t digit);
		seg_t pattern;
		case (digit)
			4'd0:    pattern = 7'b111_1110;
			4'd1:    pattern = 7'b011_0000;
			4'd2:    pattern = 7'b110_1101;
			4'd3:    pattern = 7'b111_1001;
			4'd4:    pattern = 7'b011_0011;
			4'd5:    pattern = 7'b101_1011;
			4'd6:    pattern = 7'b101_1111;
			4'd7:    pattern = 7'b111_0000;
			4'd8:    pattern = 7'b111_1111;
			4'd9:    pattern = 7'b111_1011;
			// Non-BCD input shows a dash
			default: pattern = 7'b000_0001;
		endcase
		return pattern;
	endfunction

	assign seg_score_tens = bcd_to_seg(score_tens);
	assign seg_score_ones = bcd_to_seg(score_ones);
	assign seg_time_tens  = bcd_to_seg(time_tens);
	assign seg_time_ones  = bcd_to_seg(time_ones);

	// One LED per hole, dark board when hidden
	assign hole_leds = mole_position[4] ? 16'd0 : (16'd1 << mole_position[3:0]);

endmodule

//--- design/whac_top.sv
`timescale 1ns/100ps

module whac_top #(
	parameter int STEP_TICKS    = whac_pkg::DEF_STEP_TICKS,
	parameter int TICKS_PER_SEC = whac_pkg::DEF_TICKS_PER_SEC,
	parameter int GAME_SECONDS  = whac_pkg::DEF_GAME_SECONDS
) (
	input  logic            clk_1us,
	input  logic            reset,
	input  logic            button,
	input  whac_pkg::hole_t mallet_position,
	output whac_pkg::mole_t mole_position,
	output logic            timesup,
	output whac_pkg::seg_t  seg_score_tens,
	output whac_pkg::seg_t  seg_score_ones,
	output whac_pkg::seg_t  seg_time_tens,
	output whac_pkg::seg_t  seg_time_ones,
	output logic [15:0]     hole_leds
);

	import whac_pkg::*;

	logic  press_valid;
	hole_t random;
	bcd_t  time_tens;
	bcd_t  time_ones;
	bcd_t  score_tens;
	bcd_t  score_ones;

	press_sync u_press_sync (
		.clk_1us     (clk_1us),
		.reset       (reset),
		.button      (button),
		.press_valid (press_valid)
	);

	mole_lfsr u_mole_lfsr (
		.clk_1us (clk_1us),
		.reset   (reset),
		.random  (random)
	);

	game_timer #(
		.TICKS_PER_SEC (TICKS_PER_SEC),
		.GAME_SECONDS  (GAME_SECONDS)
	) u_game_timer (
		.clk_1us   (clk_1us),
		.reset     (reset),
		.time_tens (time_tens),
		.time_ones (time_ones),
		.timesup   (timesup)
	);

	mole_ctrl #(
		.STEP_TICKS (STEP_TICKS)
	) u_mole_ctrl (
		.clk_1us         (clk_1us),
		.reset           (reset),
		.press_valid     (press_valid),
		.mallet_position (mallet_position),
		.random          (random),
		.timesup         (timesup),
		.mole_position   (mole_position),
		.score_tens      (score_tens),
		.score_ones      (score_ones)
	);

	board_display u_board_display (
		.score_tens     (score_tens),
		.score_ones     (score_ones),
		.time_tens      (time_tens),
		.time_ones      (time_ones),
		.mole_position  (mole_position),
		.seg_score_tens (seg_score_tens),
		.seg_score_ones (seg_score_ones),
		.seg_time_tens  (seg_time_tens),
		.seg_time_ones  (seg_time_ones),
		.hole_leds      (hole_leds)
	);

endmodule

//--- dv/whac_tb.sv
`timescale 1ns/100ps

module whac_tb;

	import whac_pkg::*;

	localparam int STEP_TICKS    = 20;
	localparam int TICKS_PER_SEC = 100;
	localparam int GAME_SECONDS  = 12;
	localparam int PHASE_CYCLES  = STEP_TICKS + 1;
	localparam int RESET_CYCLES  = 16;
	localparam int MAX_ROWS      = 16;

	localparam int ACT_HIT  = 0;
	localparam int ACT_MISS = 1;
	localparam int ACT_IDLE = 2;

	logic        clk_1us;
	logic        reset;
	logic        button;
	hole_t       mallet_position;
	mole_t       mole_position;
	logic        timesup;
	seg_t        seg_score_tens;
	seg_t        seg_score_ones;
	seg_t        seg_time_tens;
	seg_t        seg_time_ones;
	logic [15:0] hole_leds;

	// Segments a to g, a in the top bit
	seg_t seg_table [0:9] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33,
		7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h7b};

	string  row_name [MAX_ROWS];
	int     row_action [MAX_ROWS];
	int     row_repeat [MAX_ROWS];
	int     row_score [MAX_ROWS];
	int     row_count;
	string  test_name;
	int     ref_score;
	int     errors;
	int     checks;
	integer seed;

	whac_top #(
		.STEP_TICKS    (STEP_TICKS),
		.TICKS_PER_SEC (TICKS_PER_SEC),
		.GAME_SECONDS  (GAME_SECONDS)
	) DUT (
		.clk_1us         (clk_1us),
		.reset           (reset),
		.button          (button),
		.mallet_position (mallet_position),
		.mole_position   (mole_position),
		.timesup         (timesup),
		.seg_score_tens  (seg_score_tens),
		.seg_score_ones  (seg_score_ones),
		.seg_time_tens   (seg_time_tens),
		.seg_time_ones   (seg_time_ones),
		.hole_leds       (hole_leds)
	);

	initial begin
		clk_1us = 1'b0;
		forever #5 clk_1us = ~clk_1us;
	end

	task automatic add_row(input string name, input int action, input int repeats,
		input int score);
		row_name[row_count]   = name;
		row_action[row_count] = action;
		row_repeat[row_count] = repeats;
		row_score[row_count]  = score;
		row_count++;
	endtask

	// Name, action, repeats, expected score after the row
	task automatic load_table();
		add_row("first_hits",   ACT_HIT,  3, 3);
		add_row("miss_round",   ACT_MISS, 2, 3);
		add_row("mole_expiry",  ACT_IDLE, 1, 3);
		add_row("hits_to_nine", ACT_HIT,  6, 9);
		add_row("carry_ten",    ACT_HIT,  1, 10);
		add_row("carry_eleven", ACT_HIT,  1, 11);
		add_row("late_miss",    ACT_MISS, 1, 11);
		add_row("more_hits",    ACT_HIT,  2, 13);
	endtask

	function automatic int seg_of(input int digit);
		return int'(seg_table[digit]);
	endfunction

	// Inputs change and outputs are read 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk_1us);
		#1;
	endtask

	task automatic check_equal(input string what, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("** Error %s %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic check_score();
		check_equal("score tens", seg_of((ref_score / 10) % 10), int'(seg_score_tens));
		check_equal("score ones", seg_of(ref_score % 10), int'(seg_score_ones));
	endtask

	task automatic wait_visible();
		while (mole_position[4]) begin
			next_cycle();
		end
	endtask

	task automatic wait_hidden();
		while (!mole_position[4]) begin
			next_cycle();
		end
	endtask

	task automatic pick_other(input hole_t avoid, output hole_t hole);
		integer value;
		value = $random(seed);
		hole = value[3:0];
		while (hole == avoid) begin
			value = $random(seed);
			hole = value[3:0];
		end
	endtask

	// Button high for two cycles; the strobe lands on the third edge
	task automatic press_at(input hole_t hole);
		logic expect_hit;
		mallet_position = hole;
		button = 1'b1;
		next_cycle();
		next_cycle();
		button = 1'b0;
		next_cycle();
		expect_hit = !timesup && !mole_position[4] && (mole_position[3:0] == hole);
		if (expect_hit) ref_score = (ref_score + 1) % 100;
		next_cycle();
		check_score();
		if (expect_hit) check_equal("mole after hit", 16, int'(mole_position));
	endtask

	task automatic do_miss();
		hole_t hole;
		wait_visible();
		pick_other(mole_position[3:0], hole);
		press_at(hole);
		// Second press at hole 0 while the board is empty
		wait_hidden();
		press_at(mole_position[3:0]);
	endtask

	task automatic do_idle();
		wait_visible();
		check_equal("hole leds", int'(16'd1 << mole_position[3:0]), int'(hole_leds));
		wait_hidden();
		check_equal("mole position", 16, int'(mole_position));
		check_equal("hole leds", 0, int'(hole_leds));
		wait_visible();
		check_equal("hole leds", int'(16'd1 << mole_position[3:0]), int'(hole_leds));
		check_score();
	endtask

	task automatic run_watchdog(input int cycles);
		repeat (cycles) @(posedge clk_1us);
		$display("Watchdog expired: run did not end within %0d cycles", cycles);
		$display("Test FAILED");
		$finish;
	endtask

	initial begin
		int    limit;
		int    row;
		int    rep;
		int    n;
		hole_t hole;
		seed = 32'h58b2_ccbf;
		errors = 0;
		checks = 0;
		ref_score = 0;
		row_count = 0;
		reset = 1'b0;
		button = 1'b0;
		mallet_position = '0;
		load_table();
		limit = RESET_CYCLES + GAME_SECONDS * TICKS_PER_SEC;
		for (row = 0; row < row_count; row++) begin
			limit += row_repeat[row] * 60;
		end
		fork
			run_watchdog(limit);
		join_none

		repeat (RESET_CYCLES) @(posedge clk_1us);
		#1;
		reset = 1'b1;
		next_cycle();
		test_name = "reset_state";
		check_equal("mole position", 16, int'(mole_position));
		check_equal("hole leds", 0, int'(hole_leds));
		check_equal("timesup", 0, int'(timesup));
		check_score();
		check_equal("time tens", seg_of(GAME_SECONDS / 10), int'(seg_time_tens));
		check_equal("time ones", seg_of(GAME_SECONDS % 10), int'(seg_time_ones));

		for (row = 0; row < row_count; row++) begin
			test_name = row_name[row];
			for (rep = 0; rep < row_repeat[row]; rep++) begin
				case (row_action[row])
					ACT_HIT: begin
						wait_visible();
						press_at(mole_position[3:0]);
					end
					ACT_MISS: do_miss();
					default:  do_idle();
				endcase
			end
			check_equal("row score tens", seg_of(row_score[row] / 10), int'(seg_score_tens));
			check_equal("row score ones", seg_of(row_score[row] % 10), int'(seg_score_ones));
		end

		// Game over: no scoring, no new moles
		test_name = "time_up";
		while (!timesup) begin
			next_cycle();
		end
		check_equal("time tens", seg_of(0), int'(seg_time_tens));
		check_equal("time ones", seg_of(0), int'(seg_time_ones));
		if (!mole_position[4]) press_at(mole_position[3:0]);
		wait_hidden();
		for (n = 0; n < 4 * PHASE_CYCLES; n += 5) begin
			pick_other(mole_position[3:0], hole);
			press_at(hole);
			next_cycle();
			check_equal("mole position", 16, int'(mole_position));
			check_equal("hole leds", 0, int'(hole_leds));
		end

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
design/whac_pkg.sv
design/press_sync.sv
design/mole_lfsr.sv
design/game_timer.sv
design/mole_ctrl.sv
design/board_display.sv
design/whac_top.sv
dv/whac_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module whac_tb -o whac_sim -f flist.f

# The log, not the exit code, decides the result
./obj_dir/whac_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
